// File: Bender.yml
package:
  name: ao_peripheral_subsystem

sources:
  - ao_periph_pkg.sv
  - obi_reg_bridge.sv
  - reg_demux.sv
  - soc_ctrl.sv
  - ao_timer.sv
  - power_manager.sv
  - ao_peripheral_subsystem.sv
  - target: test
    files:
      - tb_ao_peripheral_subsystem.sv

// File: ao_periph_pkg.sv
// Always-on peripheral subsystem package
// Bus and register structs, address map and register offsets

`default_nettype none

package ao_periph_pkg;

  // CPU side request and response
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // Single register access
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Address map, upper 16 bits select the subsystem
  localparam logic [31:0] AoBase = 32'h2000_0000;
  localparam int unsigned WindowLsb = 12;

  localparam int unsigned SocCtrlIdx   = 0;
  localparam int unsigned PowerMgrIdx  = 1;
  localparam int unsigned TimerBaseIdx = 2;

  // SoC control offsets
  localparam logic [WindowLsb-1:0] SocExitValid = 12'h000;
  localparam logic [WindowLsb-1:0] SocExitValue = 12'h004;
  localparam logic [WindowLsb-1:0] SocBootSel   = 12'h008;
  localparam logic [WindowLsb-1:0] SocScratch   = 12'h00C;

  // Timer offsets
  localparam logic [WindowLsb-1:0] TmrCtrl    = 12'h000;
  localparam logic [WindowLsb-1:0] TmrCount   = 12'h004;
  localparam logic [WindowLsb-1:0] TmrCompare = 12'h008;
  localparam logic [WindowLsb-1:0] TmrStatus  = 12'h00C;

  // Power manager offsets
  localparam logic [WindowLsb-1:0] PmGate     = 12'h000;
  localparam logic [WindowLsb-1:0] PmWakeMask = 12'h004;
  localparam logic [WindowLsb-1:0] PmStatus   = 12'h008;

endpackage

`default_nettype wire

// File: ao_peripheral_subsystem.sv
// Always-on peripheral subsystem top level
// OBI bridge, window demux, SoC control, power manager and timers

`default_nettype none

module ao_peripheral_subsystem #(
  parameter int unsigned NumTimers = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  ao_periph_pkg::obi_req_t  obi_req_i,
  output ao_periph_pkg::obi_resp_t obi_resp_o,
  input  logic                     boot_select_i,
  output logic                     exit_valid_o,
  output logic [31:0]              exit_value_o,
  output logic                     power_gate_core_o,
  output logic                     cpu_rst_o,
  output logic [NumTimers-1:0]     timer_irq_o
);

  ao_periph_pkg::reg_req_t                 periph_req;
  ao_periph_pkg::reg_rsp_t                 periph_rsp;
  ao_periph_pkg::reg_req_t [NumTimers+1:0] slv_req;
  ao_periph_pkg::reg_rsp_t [NumTimers+1:0] slv_rsp;
  logic [NumTimers-1:0]                    timer_irq;

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i,
    .rst_i,
    .obi_req_i,
    .obi_resp_o,
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux #(
    .NumTimers (NumTimers)
  ) reg_demux_i (
    .in_req_i  (periph_req),
    .in_rsp_o  (periph_rsp),
    .out_req_o (slv_req),
    .out_rsp_i (slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_i,
    .reg_req_i (slv_req[ao_periph_pkg::SocCtrlIdx]),
    .reg_rsp_o (slv_rsp[ao_periph_pkg::SocCtrlIdx]),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  power_manager #(
    .NumTimers (NumTimers)
  ) power_manager_i (
    .clk_i,
    .rst_i,
    .reg_req_i   (slv_req[ao_periph_pkg::PowerMgrIdx]),
    .reg_rsp_o   (slv_rsp[ao_periph_pkg::PowerMgrIdx]),
    .timer_irq_i (timer_irq),
    .power_gate_core_o,
    .cpu_rst_o
  );

  for (genvar k = 0; k < NumTimers; k++) begin : gen_timer
    ao_timer ao_timer_i (
      .clk_i,
      .rst_i,
      .reg_req_i (slv_req[ao_periph_pkg::TimerBaseIdx + k]),
      .reg_rsp_o (slv_rsp[ao_periph_pkg::TimerBaseIdx + k]),
      .irq_o     (timer_irq[k])
    );
  end

  assign timer_irq_o = timer_irq;

endmodule

`default_nettype wire

// File: ao_timer.sv
// Always-on compare-match timer
// Counter wraps on compare, sets expired and raises an interrupt

`default_nettype none

module ao_timer (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    irq_o
);

  localparam int unsigned Lsb = ao_periph_pkg::WindowLsb;

  logic           enable_q;
  logic           irq_en_q;
  logic [31:0]    count_q;
  logic [31:0]    compare_q;
  logic           expired_q;
  logic           match;
  logic           wr;
  logic [Lsb-1:0] offset;

  assign offset = reg_req_i.addr[Lsb-1:0];
  assign wr     = reg_req_i.valid && reg_req_i.write;
  assign match  = enable_q && (count_q == compare_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q  <= 1'b0;
      irq_en_q  <= 1'b0;
      count_q   <= 32'h0;
      compare_q <= 32'h0;
      expired_q <= 1'b0;
    end else begin
      if (wr && offset == ao_periph_pkg::TmrCtrl) begin
        enable_q <= reg_req_i.wdata[0];
        irq_en_q <= reg_req_i.wdata[1];
      end
      if (wr && offset == ao_periph_pkg::TmrCompare) compare_q <= reg_req_i.wdata;

      // Software write overrides the increment
      if (wr && offset == ao_periph_pkg::TmrCount) begin
        count_q <= reg_req_i.wdata;
      end else if (enable_q) begin
        count_q <= match ? 32'h0 : count_q + 32'd1;
      end

      // Set beats write-1-to-clear
      if (match) begin
        expired_q <= 1'b1;
      end else if (wr && offset == ao_periph_pkg::TmrStatus && reg_req_i.wdata[0]) begin
        expired_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      ao_periph_pkg::TmrCtrl:    reg_rsp_o.rdata = {30'h0, irq_en_q, enable_q};
      ao_periph_pkg::TmrCount:   reg_rsp_o.rdata = count_q;
      ao_periph_pkg::TmrCompare: reg_rsp_o.rdata = compare_q;
      ao_periph_pkg::TmrStatus:  reg_rsp_o.rdata = {31'h0, expired_q};
      default:                   reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign irq_o = expired_q && irq_en_q;

endmodule

`default_nettype wire

// File: obi_reg_bridge.sv
// OBI to register bridge
// One transaction at a time, fixed three-cycle round trip

`default_nettype none

module obi_reg_bridge (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  ao_periph_pkg::obi_req_t  obi_req_i,
  output ao_periph_pkg::obi_resp_t obi_resp_o,
  output ao_periph_pkg::reg_req_t  reg_req_o,
  input  ao_periph_pkg::reg_rsp_t  reg_rsp_i
);

  typedef enum logic [1:0] {
    StIdle,
    StAccess,
    StRespond
  } state_e;

  state_e      state_q;
  logic        grant;
  logic        we_q;
  logic [3:0]  be_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;
  logic        err_q;

  assign grant = obi_req_i.req && (state_q == StIdle);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle:    if (grant) state_q <= StAccess;
        StAccess:  state_q <= StRespond;
        default:   state_q <= StIdle;
      endcase
    end
  end

  // Request capture at the grant
  always_ff @(posedge clk_i) begin
    if (grant) begin
      we_q    <= obi_req_i.we;
      be_q    <= obi_req_i.be;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
    end
    if (state_q == StAccess) begin
      rdata_q <= we_q ? 32'h0 : reg_rsp_i.rdata;
      err_q   <= reg_rsp_i.error;
    end
  end

  assign reg_req_o.valid = (state_q == StAccess);
  assign reg_req_o.write = we_q;
  assign reg_req_o.addr  = addr_q;
  assign reg_req_o.wdata = wdata_q;
  assign reg_req_o.be    = be_q;

  assign obi_resp_o.gnt    = (state_q == StIdle);
  assign obi_resp_o.rvalid = (state_q == StRespond);
  assign obi_resp_o.err    = err_q;
  assign obi_resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

// File: power_manager.sv
// Core power manager
// Gates the core and holds the CPU in reset until a masked timer wakes it

`default_nettype none

module power_manager #(
  parameter int unsigned NumTimers = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [NumTimers-1:0]    timer_irq_i,
  output logic                    power_gate_core_o,
  output logic                    cpu_rst_o
);

  localparam int unsigned Lsb = ao_periph_pkg::WindowLsb;

  typedef enum logic [1:0] {
    StOn,
    StResetHeld,
    StGated,
    StWaking
  } state_e;

  state_e               state_q;
  logic [NumTimers-1:0] wake_mask_q;
  logic [Lsb-1:0]       offset;
  logic                 wr;
  logic                 gate_req;
  logic                 wake;

  assign offset   = reg_req_i.addr[Lsb-1:0];
  assign wr       = reg_req_i.valid && reg_req_i.write;
  assign gate_req = wr && (offset == ao_periph_pkg::PmGate) && reg_req_i.wdata[0];
  assign wake     = |(timer_irq_i & wake_mask_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= StOn;
      wake_mask_q <= '0;
    end else begin
      if (wr && offset == ao_periph_pkg::PmWakeMask) begin
        wake_mask_q <= reg_req_i.wdata[NumTimers-1:0];
      end
      // Reset goes up first, gating follows; wake undoes it in reverse
      case (state_q)
        StOn:        if (gate_req) state_q <= StResetHeld;
        StResetHeld: state_q <= StGated;
        StGated:     if (wake) state_q <= StWaking;
        default:     state_q <= StOn;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b0;
    case (offset)
      ao_periph_pkg::PmGate:     reg_rsp_o.rdata[0] = power_gate_core_o;
      ao_periph_pkg::PmWakeMask: reg_rsp_o.rdata[NumTimers-1:0] = wake_mask_q;
      ao_periph_pkg::PmStatus:   reg_rsp_o.rdata[1:0] = {cpu_rst_o, power_gate_core_o};
      default:                   reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign power_gate_core_o = (state_q == StGated);
  assign cpu_rst_o         = (state_q != StOn);

endmodule

`default_nettype wire

// File: reg_demux.sv
// Register demultiplexer
// Routes an access to one peripheral by 4 KiB window, unmapped accesses error

`default_nettype none

module reg_demux #(
  parameter int unsigned NumTimers = 2
) (
  input  ao_periph_pkg::reg_req_t                 in_req_i,
  output ao_periph_pkg::reg_rsp_t                 in_rsp_o,
  output ao_periph_pkg::reg_req_t [NumTimers+1:0] out_req_o,
  input  ao_periph_pkg::reg_rsp_t [NumTimers+1:0] out_rsp_i
);

  localparam int unsigned NumPorts = NumTimers + 2;
  localparam int unsigned Lsb = ao_periph_pkg::WindowLsb;

  logic       base_hit;
  logic [3:0] idx;
  logic       idx_ok;

  assign base_hit = (in_req_i.addr[31:16] == ao_periph_pkg::AoBase[31:16]);
  assign idx      = in_req_i.addr[Lsb+3:Lsb];
  assign idx_ok   = base_hit && (32'(idx) < NumPorts);

  // Same fields everywhere, valid only on the addressed port
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = in_req_i.valid && idx_ok && (32'(idx) == i);
    end
  end

  always_comb begin
    in_rsp_o.rdata = 32'h0;
    in_rsp_o.error = 1'b1;
    for (int i = 0; i < NumPorts; i++) begin
      if (idx_ok && (32'(idx) == i)) begin
        in_rsp_o = out_rsp_i[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: soc_ctrl.sv
// SoC control registers
// Boot select readback, exit status and a scratch word

`default_nettype none

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output logic [31:0]             exit_value_o
);

  localparam int unsigned Lsb = ao_periph_pkg::WindowLsb;

  logic           exit_valid_q;
  logic [31:0]    exit_value_q;
  logic [31:0]    scratch_q;
  logic           boot_sel_q;
  logic [Lsb-1:0] offset;
  logic           wr;

  assign offset = reg_req_i.addr[Lsb-1:0];
  assign wr     = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'h0;
    end else if (wr) begin
      if (offset == ao_periph_pkg::SocExitValid) exit_valid_q <= reg_req_i.wdata[0];
      if (offset == ao_periph_pkg::SocExitValue) exit_value_q <= reg_req_i.wdata;
    end
  end

  // Scratch honors byte lanes
  always_ff @(posedge clk_i) begin
    boot_sel_q <= boot_select_i;
    if (wr && offset == ao_periph_pkg::SocScratch) begin
      for (int b = 0; b < 4; b++) begin
        if (reg_req_i.be[b]) scratch_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      ao_periph_pkg::SocExitValid: reg_rsp_o.rdata = {31'h0, exit_valid_q};
      ao_periph_pkg::SocExitValue: reg_rsp_o.rdata = exit_value_q;
      ao_periph_pkg::SocBootSel:   reg_rsp_o.rdata = {31'h0, boot_sel_q};
      ao_periph_pkg::SocScratch:   reg_rsp_o.rdata = scratch_q;
      default:                     reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// File: tb.f
ao_periph_pkg.sv
obi_reg_bridge.sv
reg_demux.sv
soc_ctrl.sv
ao_timer.sv
power_manager.sv
ao_peripheral_subsystem.sv
tb_ao_peripheral_subsystem.sv

// File: tb_ao_peripheral_subsystem.sv
// Testbench for the always-on peripheral subsystem
// Drives OBI transactions and checks registers, timers and power sequencing

`default_nettype none

module tb_ao_peripheral_subsystem;

  localparam int unsigned NumTimers = 2;
  localparam int unsigned Timeout   = 64;

  logic                     clk;
  logic                     rst;
  ao_periph_pkg::obi_req_t  obi_req;
  ao_periph_pkg::obi_resp_t obi_resp;
  logic                     boot_select;
  logic                     exit_valid;
  logic [31:0]              exit_value;
  logic                     power_gate_core;
  logic                     cpu_rst;
  logic [NumTimers-1:0]     timer_irq;

  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     errors_before;

  ao_peripheral_subsystem #(
    .NumTimers (NumTimers)
  ) dut (
    .clk_i             (clk),
    .rst_i             (rst),
    .obi_req_i         (obi_req),
    .obi_resp_o        (obi_resp),
    .boot_select_i     (boot_select),
    .exit_valid_o      (exit_valid),
    .exit_value_o      (exit_value),
    .power_gate_core_o (power_gate_core),
    .cpu_rst_o         (cpu_rst),
    .timer_irq_o       (timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Rvalid comes two cycles after the grant and gnt stays low meanwhile
  assert property (@(posedge clk) disable iff (rst)
    (obi_req.req && obi_resp.gnt) |=> (!obi_resp.gnt && !obi_resp.rvalid)
                                      ##1 (!obi_resp.gnt && obi_resp.rvalid))
  else begin
    $display("ERROR at %0t: bridge response did not come two cycles after the grant", $time);
    errors++;
  end

  function automatic logic [31:0] reg_addr(input int unsigned idx, input logic [11:0] offset);
    return ao_periph_pkg::AoBase | (32'(idx) << ao_periph_pkg::WindowLsb) | 32'(offset);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic bus_transfer(input logic we, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int n;
    obi_req.req   <= 1'b1;
    obi_req.we    <= we;
    obi_req.be    <= be;
    obi_req.addr  <= addr;
    obi_req.wdata <= wdata;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!obi_resp.gnt && n < Timeout);
    obi_req.req <= 1'b0;
    if (!obi_resp.gnt) begin
      $display("Timeout at %0t: no grant for the access to %h", $time, addr);
      errors++;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!obi_resp.rvalid && n < Timeout);
    if (!obi_resp.rvalid) begin
      $display("Timeout at %0t: the bridge never answered the access to %h", $time, addr);
      errors++;
    end
    rdata = obi_resp.rdata;
    err   = obi_resp.err;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    bus_transfer(1'b1, be, addr, wdata, rdata, err);
    check_eq("obi_resp.err", 32'h0, err);
    check_eq("obi_resp.rdata", 32'h0, rdata);
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] rdata);
    logic err;
    bus_transfer(1'b0, 4'hf, addr, 32'h0, rdata, err);
    check_eq("obi_resp.err", 32'h0, err);
  endtask

  // Unmapped accesses answer with an error and zero data
  task automatic unmapped_access(input logic we, input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    bus_transfer(we, 4'hf, addr, 32'hdead_beef, rdata, err);
    check_eq("obi_resp.err", 32'h1, err);
    check_eq("obi_resp.rdata", 32'h0, rdata);
  endtask

  task automatic start_timer(input int unsigned k, input logic [31:0] compare);
    obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrCount), 32'h0, 4'hf);
    obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrCompare), compare, 4'hf);
    obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrCtrl), 32'h3, 4'hf);
  endtask

  task automatic await_irq(input int unsigned k);
    int                   n;
    logic [NumTimers-1:0] mine;
    logic [NumTimers-1:0] stray;
    n = 0;
    mine = '0;
    mine[k] = 1'b1;
    stray = '0;
    do begin
      @(posedge clk);
      n++;
      stray = stray | (timer_irq & ~mine);
    end while (!timer_irq[k] && n < Timeout);
    if (!timer_irq[k]) begin
      $display("Timeout at %0t: timer %0d interrupt never rose", $time, k);
      errors++;
    end
    check_eq("timer_irq_o other bits", 32'h0, stray);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("[%0t] %-10s %s", $time, name, (errors == errors_before) ? "ok" : "failed");
    errors_before = errors;
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] scratch;
    logic [31:0] wdata;
    logic [3:0]  be;
    int          n;
    seed          = 32'hcfce_fcc6;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    errors_before = 0;
    rst           = 1'b1;
    obi_req       = '0;
    boot_select   = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    check_eq("obi_resp.rvalid", 32'h0, obi_resp.rvalid);
    check_eq("exit_valid_o", 32'h0, exit_valid);
    check_eq("power_gate_core_o", 32'h0, power_gate_core);
    check_eq("cpu_rst_o", 32'h0, cpu_rst);
    check_eq("timer_irq_o", 32'h0, timer_irq);
    end_test("reset");

    // Scratch merged by byte lane
    scratch = $random(seed);
    obi_write(reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocScratch), scratch, 4'hf);
    repeat (4) begin
      wdata = $random(seed);
      be = $random(seed);
      if (be == 4'h0 || be == 4'hf) be = 4'b0110;
      obi_write(reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocScratch), wdata, be);
      for (int b = 0; b < 4; b++) begin
        if (be[b]) scratch[8*b +: 8] = wdata[8*b +: 8];
      end
      obi_read(reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocScratch), rdata);
      check_eq("SocScratch", scratch, rdata);
    end
    boot_select <= 1'b1;
    obi_read(reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocBootSel), rdata);
    check_eq("SocBootSel", 32'h1, rdata);
    boot_select <= 1'b0;
    obi_read(reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocBootSel), rdata);
    check_eq("SocBootSel", 32'h0, rdata);
    wdata = $random(seed);
    obi_write(reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocExitValue), wdata, 4'hf);
    obi_write(reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocExitValid), 32'h1, 4'hf);
    check_eq("exit_value_o", wdata, exit_value);
    check_eq("exit_valid_o", 32'h1, exit_valid);
    end_test("soc_ctrl");

    // Outside the base, then an index past the last timer
    unmapped_access(1'b1, reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocScratch)
                          ^ 32'h0001_0000);
    unmapped_access(1'b0, reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocScratch)
                          ^ 32'h0001_0000);
    unmapped_access(1'b1, reg_addr(ao_periph_pkg::TimerBaseIdx + NumTimers, 12'h00C));
    unmapped_access(1'b0, reg_addr(ao_periph_pkg::TimerBaseIdx + NumTimers, 12'h00C));
    obi_read(reg_addr(ao_periph_pkg::SocCtrlIdx, ao_periph_pkg::SocScratch), rdata);
    check_eq("SocScratch", scratch, rdata);
    end_test("unmapped");

    for (int unsigned k = 0; k < NumTimers; k++) begin
      start_timer(k, 32'd4 + ($random(seed) & 32'hf));
      await_irq(k);
      obi_read(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrStatus), rdata);
      check_eq("TmrStatus", 32'h1, rdata);
      // Hold the count so the clear cannot race a new match
      obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrCtrl), 32'h2, 4'hf);
      obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrStatus), 32'h1, 4'hf);
      check_eq("timer_irq_o", 32'h0, timer_irq);
      obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrCtrl), 32'h3, 4'hf);
      await_irq(k);
      obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrCtrl), 32'h0, 4'hf);
      obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + k, ao_periph_pkg::TmrStatus), 32'h1, 4'hf);
    end
    end_test("timers");

    obi_write(reg_addr(ao_periph_pkg::PowerMgrIdx, ao_periph_pkg::PmWakeMask), 32'h1, 4'hf);
    obi_write(reg_addr(ao_periph_pkg::PowerMgrIdx, ao_periph_pkg::PmGate), 32'h1, 4'hf);
    check_eq("cpu_rst_o", 32'h1, cpu_rst);
    check_eq("power_gate_core_o", 32'h0, power_gate_core);
    @(posedge clk);
    check_eq("power_gate_core_o", 32'h1, power_gate_core);
    obi_read(reg_addr(ao_periph_pkg::PowerMgrIdx, ao_periph_pkg::PmStatus), rdata);
    check_eq("PmStatus", 32'h3, rdata);
    // Masked out timer must not wake the core
    start_timer(1, 32'd4 + ($random(seed) & 32'hf));
    await_irq(1);
    @(posedge clk);
    check_eq("power_gate_core_o", 32'h1, power_gate_core);
    obi_read(reg_addr(ao_periph_pkg::PowerMgrIdx, ao_periph_pkg::PmStatus), rdata);
    check_eq("PmStatus", 32'h3, rdata);
    obi_write(reg_addr(ao_periph_pkg::TimerBaseIdx + 1, ao_periph_pkg::TmrCtrl), 32'h0, 4'hf);
    start_timer(0, 32'd4 + ($random(seed) & 32'hf));
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (power_gate_core && n < Timeout);
    if (power_gate_core) begin
      $display("Timeout at %0t: timer 0 never woke the core", $time);
      errors++;
    end
    check_eq("cpu_rst_o", 32'h1, cpu_rst);
    check_eq("timer_irq_o", 32'h1, timer_irq);
    @(posedge clk);
    check_eq("cpu_rst_o", 32'h0, cpu_rst);
    obi_read(reg_addr(ao_periph_pkg::PowerMgrIdx, ao_periph_pkg::PmStatus), rdata);
    check_eq("PmStatus", 32'h0, rdata);
    end_test("power_mgr");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
